// File: dcache_defs.svh
`ifndef DCACHE_DEFS_SVH
`define DCACHE_DEFS_SVH

// Datapath word and address width
`define DCACHE_WORD_W 32

// Address split
// 26 tag | 3 index | 1 block offset | 2 byte offset
`define DCACHE_TAG_W 26
`define DCACHE_IDX_W 3
`define DCACHE_BYTE_W 2

// Two ways per set, eight sets
`define DCACHE_SETS 8

// Address and store value when no memory access is running
// Easy to spot in a waveform
`define DCACHE_ERR_ADDR 32'hECE43700

`endif

// File: dcache_pkg.sv
`include "dcache_defs.svh"

package dcache_pkg;

	// Plain data word
	typedef logic [`DCACHE_WORD_W-1:0] word_t;

	// Address pieces
	typedef logic [`DCACHE_TAG_W-1:0] tag_t;
	typedef logic [`DCACHE_IDX_W-1:0] idx_t;

	// Datapath address as seen by the cache
	typedef struct packed {
		tag_t tag;
		idx_t idx;
		logic blkoff;
		logic [`DCACHE_BYTE_W-1:0] byteoff;
	} dcache_addr_fields_t;

	// Same 32 bits, raw word or decoded fields
	typedef union packed {
		word_t raw;
		dcache_addr_fields_t f;
	} dcache_addr_u;

	// One way of one set, {index, way}
	typedef logic [`DCACHE_IDX_W:0] slot_t;

	// Miss and flush controller states
	typedef enum logic [3:0] {
		IDLE, WB1, WB2, FD1, FD2, DCHK, WBD1, WBD2, FLUSHED
	} ctrl_state_t;

endpackage

// File: dcache_lookup.sv
module dcache_lookup import dcache_pkg::*; (
	// Request from the datapath
	input dcache_addr_u addr,
	input logic req,
	// Indexed set from the array
	input logic [1:0] valid,
	input tag_t tag0,
	input tag_t tag1,
	input word_t [1:0] data0,
	input word_t [1:0] data1,
	input logic [1:0] dirty,
	input logic lru,
	// Controller sits in IDLE
	input logic idle,
	output logic hit,
	output logic hit_way,
	output word_t load,
	output logic victim_way,
	output logic victim_dirty
);

	// Per way tag match
	logic match0;
	logic match1;

	//////////////////////////////////////////////////////////////////////
	// Tag compare
	//////////////////////////////////////////////////////////////////////

	// A way matches only when it holds valid data
	assign match0 = valid[0] && (tag0 == addr.f.tag);
	assign match1 = valid[1] && (tag1 == addr.f.tag);

	// Hit only counts for a live request while no miss is in progress
	assign hit = req && idle && (match0 || match1);

	// Way 1 wins the select, way 0 otherwise
	assign hit_way = match1;

	//////////////////////////////////////////////////////////////////////
	// Load data
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		// Word picked by the block offset
		if (hit_way) begin
			load = data1[addr.f.blkoff];
		end else begin
			load = data0[addr.f.blkoff];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Replacement choice
	//////////////////////////////////////////////////////////////////////

	// LRU bit names the way to replace
	assign victim_way = lru;

	// Victim needs a write-back first when dirty
	assign victim_dirty = dirty[lru];

	// A block is only ever filled into one way of a set
	always_comb begin
		assert final (!(match0 && match1))
			else $error("dcache_lookup: both ways match tag %h", addr.f.tag);
	end

endmodule

// File: dcache_array.sv
`include "dcache_defs.svh"

module dcache_array import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	// Request fields
	input idx_t idx,
	input tag_t addr_tag,
	input logic blkoff,
	// Hit from the lookup
	input logic hit,
	input logic hit_way,
	input logic wen,
	input logic ren,
	input word_t store,
	// Fill from memory
	input logic fill_word,
	input logic fill_en,
	input word_t fill_data,
	input logic victim_way,
	// Flush clean
	input logic clean_en,
	input slot_t clean_slot,
	// Write-back read port
	input slot_t rd_slot,
	input logic rd_word,
	// Indexed set
	output logic [1:0] valid,
	output tag_t tag0,
	output tag_t tag1,
	output word_t [1:0] data0,
	output word_t [1:0] data1,
	output logic [1:0] dirty,
	output logic lru,
	// Addressed slot
	output tag_t rd_tag,
	output word_t rd_data,
	// Dirty search
	output logic some_dirty,
	output slot_t first_dirty
);

	// Control bits, one pair per set
	logic [`DCACHE_SETS-1:0][1:0] valid_q;
	logic [`DCACHE_SETS-1:0][1:0] dirty_q;
	// LRU way per set
	logic [`DCACHE_SETS-1:0] lru_q;

	// Payload, two words per way
	tag_t tag_q [`DCACHE_SETS][2];
	word_t [1:0] data_q [`DCACHE_SETS][2];

	//////////////////////////////////////////////////////////////////////
	// Control bits
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			valid_q <= '0;
			dirty_q <= '0;
			lru_q <= '0;
		end else begin
			if (hit && wen) begin
				// Write hit marks the way dirty and makes the other way LRU
				dirty_q[idx][hit_way] <= 1'b1;
				lru_q[idx] <= ~hit_way;
			end else if (hit && ren) begin
				lru_q[idx] <= ~hit_way;
			end
			// Second fill word completes the block
			if (fill_en && fill_word) begin
				valid_q[idx][victim_way] <= 1'b1;
				dirty_q[idx][victim_way] <= 1'b0;
			end
			// Written back during flush
			if (clean_en) begin
				dirty_q[clean_slot[`DCACHE_IDX_W:1]][clean_slot[0]] <= 1'b0;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Tags and data
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (hit && wen) begin
			data_q[idx][hit_way][blkoff] <= store;
		end
		if (fill_en) begin
			data_q[idx][victim_way][fill_word] <= fill_data;
			// Tag goes in with the last word
			if (fill_word) begin
				tag_q[idx][victim_way] <= addr_tag;
			end
		end
	end

	// Indexed set for the lookup
	assign valid = valid_q[idx];
	assign dirty = dirty_q[idx];
	assign lru = lru_q[idx];
	assign tag0 = tag_q[idx][0];
	assign tag1 = tag_q[idx][1];
	assign data0 = data_q[idx][0];
	assign data1 = data_q[idx][1];

	// Slot picked by the controller for write-back
	assign rd_tag = tag_q[rd_slot[`DCACHE_IDX_W:1]][rd_slot[0]];
	assign rd_data = data_q[rd_slot[`DCACHE_IDX_W:1]][rd_slot[0]][rd_word];

	//////////////////////////////////////////////////////////////////////
	// Dirty search
	//////////////////////////////////////////////////////////////////////

	// Last dirty slot found wins, so the highest number
	always_comb begin
		some_dirty = 1'b0;
		first_dirty = '0;
		for (int set = 0; set < `DCACHE_SETS; set++) begin
			for (int way = 0; way < 2; way++) begin
				if (dirty_q[set][way]) begin
					some_dirty = 1'b1;
					first_dirty = {idx_t'(set), way[0]};
				end
			end
		end
	end

	// Fills only run outside IDLE, hits only inside it
	assert property (@(posedge CLK) disable iff (!nRST) !(fill_en && hit && wen))
		else $error("dcache_array: fill and write hit in the same cycle");

endmodule

// File: dcache_mem_ctrl.sv
`include "dcache_defs.svh"

module dcache_mem_ctrl import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	input logic halt,
	// Request side
	input logic miss,
	input tag_t tag,
	input idx_t idx,
	input logic victim_way,
	input logic victim_dirty,
	// From the array
	input logic some_dirty,
	input slot_t first_dirty,
	input tag_t rd_tag,
	input word_t rd_data,
	// Memory side
	input logic dwait,
	input word_t dload,
	output logic idle,
	// Fill and clean strobes
	output logic fill_en,
	output logic fill_word,
	output word_t fill_data,
	output logic clean_en,
	output slot_t clean_slot,
	// Write-back read port
	output slot_t rd_slot,
	output logic rd_word,
	// Memory requests
	output logic dren,
	output logic dwen,
	output word_t daddr,
	output word_t dstore,
	output logic flushed
);

	ctrl_state_t state;
	ctrl_state_t next_state;

	// Second word of the block
	logic word_sel;
	// Flush write-back, as opposed to miss write-back
	logic flush_wb;
	// Slot being written back
	slot_t wb_slot;

	//////////////////////////////////////////////////////////////////////
	// State register and next state
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			state <= IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				// Halt takes priority over a pending access
				if (halt) begin
					next_state = DCHK;
				end else if (miss) begin
					next_state = victim_dirty ? WB1 : FD1;
				end
			end
			// Memory states move on when the word completes
			WB1:  if (!dwait) next_state = WB2;
			WB2:  if (!dwait) next_state = FD1;
			FD1:  if (!dwait) next_state = FD2;
			FD2:  if (!dwait) next_state = IDLE;
			// Anything left to flush
			DCHK: next_state = some_dirty ? WBD1 : FLUSHED;
			WBD1: if (!dwait) next_state = WBD2;
			WBD2: if (!dwait) next_state = DCHK;
			// Held until reset
			FLUSHED: next_state = FLUSHED;
			default: next_state = IDLE;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// State decode
	//////////////////////////////////////////////////////////////////////

	assign idle = (state == IDLE);
	assign flushed = (state == FLUSHED);
	assign dren = (state == FD1) || (state == FD2);
	assign flush_wb = (state == WBD1) || (state == WBD2);
	assign dwen = (state == WB1) || (state == WB2) || flush_wb;
	assign word_sel = (state == WB2) || (state == FD2) || (state == WBD2);

	// Victim slot on a miss, lowest priority dirty slot on a flush
	assign wb_slot = flush_wb ? first_dirty : {idx, victim_way};
	assign rd_slot = wb_slot;
	assign rd_word = word_sel;

	// Fill each word as memory delivers it
	assign fill_en = dren && !dwait;
	assign fill_word = word_sel;
	assign fill_data = dload;

	// Slot is clean once its second word is in memory
	assign clean_en = (state == WBD2) && !dwait;
	assign clean_slot = first_dirty;

	//////////////////////////////////////////////////////////////////////
	// Memory address and store data
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		daddr = `DCACHE_ERR_ADDR;
		dstore = `DCACHE_ERR_ADDR;
		if (dwen) begin
			// Stored tag of the slot going out
			daddr = {rd_tag, wb_slot[`DCACHE_IDX_W:1], word_sel, {`DCACHE_BYTE_W{1'b0}}};
			dstore = rd_data;
		end else if (dren) begin
			// Requested block
			daddr = {tag, idx, word_sel, {`DCACHE_BYTE_W{1'b0}}};
		end
	end

	// One memory direction at a time
	assert property (@(posedge CLK) disable iff (!nRST) !(dren && dwen))
		else $error("dcache_mem_ctrl: dren and dwen both high");

	// Address holds while memory stalls
	assert property (@(posedge CLK) disable iff (!nRST)
		(dren || dwen) && dwait |=> $stable(daddr))
		else $error("dcache_mem_ctrl: daddr moved during dwait");

endmodule

// File: dcache.sv
module dcache import dcache_pkg::*; (
	input logic CLK,
	input logic nRST,
	// Datapath side
	input logic halt,
	input logic dmem_ren,
	input logic dmem_wen,
	input dcache_addr_u dmem_addr,
	input word_t dmem_store,
	output logic dhit,
	output word_t dmem_load,
	output logic flushed,
	// Memory side
	input logic dwait,
	input word_t dload,
	output logic dren,
	output logic dwen,
	output word_t daddr,
	output word_t dstore
);

	// Request and its outcome
	logic req;
	logic miss;
	logic hit;
	logic hit_way;
	logic victim_way;
	logic victim_dirty;
	logic idle;

	// Indexed set
	logic [1:0] set_valid;
	logic [1:0] set_dirty;
	logic set_lru;
	tag_t set_tag0;
	tag_t set_tag1;
	word_t [1:0] set_data0;
	word_t [1:0] set_data1;

	// Controller to array
	logic fill_en;
	logic fill_word;
	word_t fill_data;
	logic clean_en;
	slot_t clean_slot;
	slot_t rd_slot;
	logic rd_word;

	// Array to controller
	tag_t rd_tag;
	word_t rd_data;
	logic some_dirty;
	slot_t first_dirty;

	assign req = dmem_ren || dmem_wen;
	assign miss = req && !hit;
	assign dhit = hit;

	//////////////////////////////////////////////////////////////////////
	// Blocks
	//////////////////////////////////////////////////////////////////////

	dcache_lookup u_lookup (
		.addr(dmem_addr),
		.req(req),
		.valid(set_valid),
		.tag0(set_tag0),
		.tag1(set_tag1),
		.data0(set_data0),
		.data1(set_data1),
		.dirty(set_dirty),
		.lru(set_lru),
		.idle(idle),
		.hit(hit),
		.hit_way(hit_way),
		.load(dmem_load),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty)
	);

	dcache_array u_array (
		.CLK(CLK),
		.nRST(nRST),
		.idx(dmem_addr.f.idx),
		.addr_tag(dmem_addr.f.tag),
		.blkoff(dmem_addr.f.blkoff),
		.hit(hit),
		.hit_way(hit_way),
		.wen(dmem_wen),
		.ren(dmem_ren),
		.store(dmem_store),
		.fill_word(fill_word),
		.fill_en(fill_en),
		.fill_data(fill_data),
		.victim_way(victim_way),
		.clean_en(clean_en),
		.clean_slot(clean_slot),
		.rd_slot(rd_slot),
		.rd_word(rd_word),
		.valid(set_valid),
		.tag0(set_tag0),
		.tag1(set_tag1),
		.data0(set_data0),
		.data1(set_data1),
		.dirty(set_dirty),
		.lru(set_lru),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.some_dirty(some_dirty),
		.first_dirty(first_dirty)
	);

	dcache_mem_ctrl u_mem_ctrl (
		.CLK(CLK),
		.nRST(nRST),
		.halt(halt),
		.miss(miss),
		.tag(dmem_addr.f.tag),
		.idx(dmem_addr.f.idx),
		.victim_way(victim_way),
		.victim_dirty(victim_dirty),
		.some_dirty(some_dirty),
		.first_dirty(first_dirty),
		.rd_tag(rd_tag),
		.rd_data(rd_data),
		.dwait(dwait),
		.dload(dload),
		.idle(idle),
		.fill_en(fill_en),
		.fill_word(fill_word),
		.fill_data(fill_data),
		.clean_en(clean_en),
		.clean_slot(clean_slot),
		.rd_slot(rd_slot),
		.rd_word(rd_word),
		.dren(dren),
		.dwen(dwen),
		.daddr(daddr),
		.dstore(dstore),
		.flushed(flushed)
	);

endmodule

// File: tb_dcache.sv
`include "dcache_defs.svh"

module tb_dcache import dcache_pkg::*; ();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int unsigned RNG_SEED = 32'h15300d5e;
	localparam int MEM_WORDS = 1024;
	localparam int RESET_CYCLES = 5;

	logic CLK;
	logic nRST;
	logic halt;
	logic dmem_ren;
	logic dmem_wen;
	dcache_addr_u dmem_addr;
	word_t dmem_store;
	logic dhit;
	word_t dmem_load;
	logic flushed;
	logic dwait;
	word_t dload;
	logic dren;
	logic dwen;
	word_t daddr;
	word_t dstore;

	// Memory model, word addressed
	word_t mem [MEM_WORDS];
	int unsigned wait_left;

	// Trace entries in file order, preloads left out
	logic [7:0] op_q[$];
	word_t addr_q[$];
	word_t data_q[$];

	// Expected tags and LRU of every set, for hit prediction
	tag_t ref_tag [`DCACHE_SETS][2];
	logic ref_valid [`DCACHE_SETS][2];
	logic ref_lru [`DCACHE_SETS];

	int cycles;
	int cycle_limit;

	dcache DUT (.*);

	// Read data straight from the array
	assign dload = mem[daddr[11:2]];

	initial begin
		CLK = 1'b0;
		forever #10 CLK = ~CLK;
	end

	//////////////////////////////////////////////////////////////////////
	// Checks
	//////////////////////////////////////////////////////////////////////

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("*** FAILED ***");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_load(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			report_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_mem(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			report_error($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			report_error($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Memory model
	//////////////////////////////////////////////////////////////////////

	// Each word waits 0 to 3 cycles, drawn when the previous one ends
	initial begin
		int unsigned draw;
		void'($urandom(RNG_SEED));
		dwait = 1'b1;
		wait_left = 0;
		forever begin
			@(posedge CLK);
			if ((dren || dwen) && daddr[31:12] != '0) begin
				report_error($sformatf("Memory access at %h is outside the model", daddr));
			end
			if ((dren || dwen) && dwait) begin
				wait_left <= wait_left - 1;
				dwait <= (wait_left > 1);
			end else begin
				// Word done or bus idle
				if (dwen && !dwait) begin
					mem[daddr[11:2]] <= dstore;
				end
				draw = $urandom % 4;
				wait_left <= draw;
				dwait <= (draw != 0);
			end
		end
	end

	// Timeout
	initial begin
		cycles = 0;
		forever begin
			@(posedge CLK);
			cycles++;
			if (cycle_limit > 0 && cycles > cycle_limit) begin
				report_error($sformatf("Run timed out after %0d cycles", cycles));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Datapath side
	//////////////////////////////////////////////////////////////////////

	// One access, held until dhit
	task automatic access(input logic write, input word_t addr, input word_t value);
		dcache_addr_u a;
		logic expect_hit;
		logic way;
		a.raw = addr;
		// Miss fills the LRU way
		way = ref_lru[a.f.idx];
		expect_hit = 1'b0;
		for (int w = 0; w < 2; w++) begin
			if (ref_valid[a.f.idx][w] && ref_tag[a.f.idx][w] == a.f.tag) begin
				expect_hit = 1'b1;
				way = w[0];
			end
		end
		@(posedge CLK);
		dmem_addr <= a;
		dmem_ren <= !write;
		dmem_wen <= write;
		dmem_store <= write ? value : '0;
		@(negedge CLK);
		check_flag($sformatf("hit in first cycle at %h", addr), expect_hit, dhit);
		while (!dhit) begin
			check_flag("flushed during access", 1'b0, flushed);
			@(negedge CLK);
		end
		if (!write) begin
			check_load($sformatf("read at %h", addr), value, dmem_load);
		end
		@(posedge CLK);
		dmem_ren <= 1'b0;
		dmem_wen <= 1'b0;
		ref_valid[a.f.idx][way] = 1'b1;
		ref_tag[a.f.idx][way] = a.f.tag;
		ref_lru[a.f.idx] = ~way;
	endtask

	task automatic flush_all();
		@(posedge CLK);
		halt <= 1'b1;
		@(negedge CLK);
		check_flag("flushed as halt rises", 1'b0, flushed);
		while (!flushed) begin
			@(negedge CLK);
		end
		// Held until reset
		repeat (2) @(negedge CLK);
		check_flag("flushed held high", 1'b1, flushed);
	endtask

	initial begin
		int fd;
		int n;
		int lines;
		string line;
		logic [7:0] op;
		word_t a;
		word_t d;
		nRST = 1'b0;
		halt = 1'b0;
		dmem_ren = 1'b0;
		dmem_wen = 1'b0;
		dmem_addr = '0;
		dmem_store = '0;
		cycle_limit = 0;
		// Background pattern from the byte address
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = 32'hC0DE0000 | word_t'(i << 2);
		end
		for (int s = 0; s < `DCACHE_SETS; s++) begin
			ref_valid[s][0] = 1'b0;
			ref_valid[s][1] = 1'b0;
			ref_lru[s] = 1'b0;
		end
		fd = $fopen("dcache_trace.txt", "r");
		if (fd == 0) begin
			report_error("Could not open dcache_trace.txt");
		end
		lines = 0;
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (line.len() < 1) continue;
			op = line.getc(0);
			// Comments and blank lines
			if (op == "#" || op == "\n" || op == " ") continue;
			a = '0;
			d = '0;
			n = $sscanf(line.substr(1, line.len() - 1), "%h %h", a, d);
			if (op != "H" && n != 2) begin
				report_error($sformatf("Malformed trace line %s", line));
			end
			lines++;
			if (op == "M") begin
				mem[a[11:2]] = d;
			end else begin
				op_q.push_back(op);
				addr_q.push_back(a);
				data_q.push_back(d);
			end
		end
		$fclose(fd);
		cycle_limit = 40 * lines;

		repeat (RESET_CYCLES) @(posedge CLK);
		nRST <= 1'b1;
		@(negedge CLK);
		check_flag("flushed after reset", 1'b0, flushed);
		check_flag("dhit after reset", 1'b0, dhit);
		check_flag("dren after reset", 1'b0, dren);
		check_flag("dwen after reset", 1'b0, dwen);
		// Idle memory bus shows the marker value
		check_mem("daddr after reset", `DCACHE_ERR_ADDR, daddr);
		check_mem("dstore after reset", `DCACHE_ERR_ADDR, dstore);

		for (int k = 0; k < op_q.size(); k++) begin
			a = addr_q[k];
			case (op_q[k])
				"R": access(1'b0, a, data_q[k]);
				"W": access(1'b1, a, data_q[k]);
				"H": flush_all();
				"C": check_mem($sformatf("memory word %h", a), data_q[k], mem[a[11:2]]);
				default: report_error($sformatf("Unknown trace entry %c", op_q[k]));
			endcase
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: dcache.f
+incdir+.
dcache_pkg.sv
dcache_lookup.sv
dcache_array.sv
dcache_mem_ctrl.sv
dcache.sv
tb_dcache.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the dcache testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps \
	--top-module tb_dcache -f dcache.f -o sim_dcache

# A failing run exits non-zero, keep its output for the search below
output=$(./obj_dir/sim_dcache || true)
echo "$output"

if grep -qF -- "*** PASSED ***" <<< "$output"; then
	exit 0
else
	exit 1
fi

// File: dcache_trace.txt
# Columns: op, byte address (hex), data (hex)
# M preload, R read with expected load, W write, H halt, C memory word after flush
M 000 11110000
M 004 11110004
M 040 22220040
M 044 22220044
M 080 33330080
M 084 33330084
M 008 44440008
M 00C 4444000C
M 118 55550118
M 11C 5555011C
# Cold miss, then the other word of the block hits
R 000 11110000
R 004 11110004
# Write hit, read back
W 004 AAAA0004
R 004 AAAA0004
# Third tag in set 0 evicts the dirty way, re-read sees the written-back word
R 040 22220040
R 080 33330080
R 004 AAAA0004
R 000 11110000
# Write misses leave dirty blocks in sets 0, 1 and 3
W 044 BBBB0044
W 008 CCCC0008
R 00C 4444000C
W 11C DDDD011C
R 118 55550118
R 11C DDDD011C
W 000 EEEE0000
R 044 BBBB0044
# Flush, then every dirty word must be in memory
H
C 000 EEEE0000
C 004 AAAA0004
C 040 22220040
C 044 BBBB0044
C 008 CCCC0008
C 00C 4444000C
C 118 55550118
C 11C DDDD011C
C 080 33330080
